//--- verilog/bpu_pkg.sv
`default_nettype none

package bpu_pkg;

    // ------------------------------
    // Sizes
    // ------------------------------
    localparam int VADDR_SIZE    = 32;
    localparam int UBTB_SIZE     = 8;
    localparam int UBTB_IDX_SIZE = $clog2(UBTB_SIZE);
    localparam int UBTB_TAG_SIZE = 12;            // Fetch address bits 13:2
    localparam int BLOCK_INSTRS  = 8;
    localparam int BLOCK_BYTES   = 32;
    localparam int FQ_DEPTH      = 4;
    localparam int FQ_PTR_SIZE   = $clog2(FQ_DEPTH);
    localparam int FQ_CNT_SIZE   = $clog2(FQ_DEPTH + 1);
    localparam int LFSR_SIZE     = 8;
    localparam logic [LFSR_SIZE-1:0] LFSR_SEED = 8'h01;
    localparam int APB_ADDR_SIZE = 8;

    // ------------------------------
    // Types
    // ------------------------------
    typedef enum logic {
        BR_COND = 1'b0,
        BR_JUMP = 1'b1
    } br_type_e;

    typedef enum logic [2:0] {
        REG_STATUS      = 3'd0,
        REG_HEAD_START  = 3'd1,
        REG_HEAD_TARGET = 3'd2,
        REG_HEAD_INFO   = 3'd3,
        REG_UPD_ADDR    = 3'd4,
        REG_UPD_TARGET  = 3'd5,
        REG_UPD_CTRL    = 3'd6,
        REG_REDIRECT    = 3'd7
    } apb_reg_e;                                  // Word offsets

    typedef struct packed {
        logic                     en;
        logic [UBTB_TAG_SIZE-1:0] tag;
        br_type_e                 br_type;
        logic [2:0]               offset;         // Instruction slot in block
        logic [VADDR_SIZE-1:0]    target;
    } btb_entry_t;

    typedef struct packed {
        logic [VADDR_SIZE-1:0] start_addr;
        logic [VADDR_SIZE-1:0] target;
        logic [3:0]            size;              // 1 to 8 instructions
        logic                  taken;
        logic                  hit;
    } pred_stream_t;

    typedef struct packed {
        logic [VADDR_SIZE-1:0] start_addr;
        logic [VADDR_SIZE-1:0] target;
        logic [2:0]            offset;
        br_type_e              br_type;
        logic                  real_taken;
    } btb_update_t;

endpackage

`default_nettype wire

//--- verilog/fq_if.sv
`timescale 1ns/100ps
`default_nettype none

interface fq_if import bpu_pkg::*; ();

    logic                   push;
    logic                   push_ready;       // Queue not full
    pred_stream_t           push_data;
    logic                   pop;
    pred_stream_t           head;
    logic [FQ_CNT_SIZE-1:0] count;
    logic                   flush;            // Beats a push in the same cycle

    modport producer (
        output push, push_data,
        input  push_ready
    );

    modport queue (
        input  push, push_data, pop, flush,
        output push_ready, head, count
    );

    modport reader (
        output pop, flush,
        input  head, count
    );

endinterface

`default_nettype wire

//--- verilog/pc_gen.sv
`timescale 1ns/100ps
`default_nettype none

module pc_gen import bpu_pkg::*; (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  redirect_valid,
    input  logic [VADDR_SIZE-1:0] redirect_pc,
    output logic [VADDR_SIZE-1:0] pc,
    input  pred_stream_t          pred,
    fq_if.producer                fq
);

    logic                  running_q;
    logic [VADDR_SIZE-1:0] addr_q;
    logic                  accepted;

    assign accepted = fq.push && fq.push_ready;

    // ------------------------------
    // Fetch address
    // ------------------------------
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            running_q <= 1'b0;                    // Idle until first redirect
            addr_q    <= '0;
        end else if (redirect_valid) begin
            running_q <= 1'b1;
            addr_q    <= redirect_pc;
        end else if (accepted) begin
            addr_q    <= pred.target;             // Follow predicted stream
        end
    end

    assign pc = addr_q;

    // Push held steady while the queue is full
    assign fq.push      = running_q;
    assign fq.push_data = pred;

endmodule

`default_nettype wire

//--- verilog/ubtb.sv
`timescale 1ns/100ps
`default_nettype none

module ubtb import bpu_pkg::*; (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic [VADDR_SIZE-1:0] pc,
    output pred_stream_t          pred,
    input  logic                  upd_valid,
    input  btb_update_t           upd
);

    btb_entry_t               entries [UBTB_SIZE];
    logic [1:0]               ctrs [UBTB_SIZE];
    logic [UBTB_SIZE-1:0]     lookup_hits;
    logic [UBTB_SIZE-1:0]     upd_hits;
    logic [UBTB_SIZE-1:0]     way_free;
    logic [UBTB_IDX_SIZE-1:0] lookup_idx;
    logic [UBTB_IDX_SIZE-1:0] upd_idx;
    logic [UBTB_IDX_SIZE-1:0] free_idx;
    logic [UBTB_IDX_SIZE-1:0] sel_idx;
    logic [UBTB_TAG_SIZE-1:0] lookup_tag;
    logic [UBTB_TAG_SIZE-1:0] upd_tag;
    logic [LFSR_SIZE-1:0]     lfsr_q;
    btb_entry_t               hit_entry;
    logic [1:0]               hit_ctr;
    logic [1:0]               new_ctr;
    logic                     lookup_hit;
    logic                     upd_hit;
    logic                     pred_taken;

    // Lowest set bit, also the encoder for a one-hot vector
    function automatic logic [UBTB_IDX_SIZE-1:0] first_set(input logic [UBTB_SIZE-1:0] v);
        logic [UBTB_IDX_SIZE-1:0] idx;
        idx = '0;
        for (int i = UBTB_SIZE - 1; i >= 0; i--) begin
            if (v[i]) begin
                idx = UBTB_IDX_SIZE'(i);
            end
        end
        return idx;
    endfunction

    assign lookup_tag = pc[UBTB_TAG_SIZE+1:2];
    assign upd_tag    = upd.start_addr[UBTB_TAG_SIZE+1:2];

    always_comb begin
        for (int i = 0; i < UBTB_SIZE; i++) begin
            lookup_hits[i] = entries[i].en && (entries[i].tag == lookup_tag);
            upd_hits[i]    = entries[i].en && (entries[i].tag == upd_tag);
            way_free[i]    = !entries[i].en;
        end
    end

    // ------------------------------
    // Lookup
    // ------------------------------
    assign lookup_hit = |lookup_hits;
    assign lookup_idx = first_set(lookup_hits);
    assign hit_entry  = entries[lookup_idx];
    assign hit_ctr    = ctrs[lookup_idx];
    assign pred_taken = lookup_hit && ((hit_entry.br_type == BR_JUMP) ||
                        (hit_entry.br_type == BR_COND && hit_ctr[1]));

    always_comb begin
        pred.start_addr = pc;
        pred.hit        = lookup_hit;
        pred.taken      = pred_taken;
        if (pred_taken) begin
            pred.target = hit_entry.target;
            pred.size   = {1'b0, hit_entry.offset} + 4'd1;
        end else begin
            pred.target = pc + VADDR_SIZE'(BLOCK_BYTES);    // Fall through
            pred.size   = 4'(BLOCK_INSTRS);
        end
    end

    // ------------------------------
    // Update and replacement
    // ------------------------------
    assign upd_hit  = |upd_hits;
    assign upd_idx  = first_set(upd_hits);
    assign free_idx = first_set(way_free);
    assign sel_idx  = upd_hit     ? upd_idx  :
                      (|way_free) ? free_idx : lfsr_q[UBTB_IDX_SIZE-1:0];

    always_comb begin
        if (!upd_hit) begin
            new_ctr = upd.real_taken ? 2'd2 : 2'd1;                     // Weak start
        end else if (upd.real_taken) begin
            new_ctr = (ctrs[upd_idx] == 2'd3) ? 2'd3 : ctrs[upd_idx] + 2'd1;
        end else begin
            new_ctr = (ctrs[upd_idx] == 2'd0) ? 2'd0 : ctrs[upd_idx] - 2'd1;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            lfsr_q <= LFSR_SEED;
        end else if (upd_valid && !upd_hit && !(|way_free)) begin
            lfsr_q <= {lfsr_q[6:0], lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3]};
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < UBTB_SIZE; i++) begin
                entries[i] <= '0;
                ctrs[i]    <= 2'd0;
            end
        end else if (upd_valid) begin
            entries[sel_idx] <= '{en: 1'b1, tag: upd_tag, br_type: upd.br_type,
                                  offset: upd.offset, target: upd.target};
            ctrs[sel_idx]    <= new_ctr;
        end
    end

    // A tag is only ever allocated once, so at most one way can match
    upd_hit_onehot_a: assert property (@(posedge clk) disable iff (!arst_n)
        upd_valid |-> $onehot0(upd_hits));
    lookup_hit_onehot_a: assert property (@(posedge clk) disable iff (!arst_n)
        $onehot0(lookup_hits));

endmodule

`default_nettype wire

//--- verilog/fetch_queue.sv
`timescale 1ns/100ps
`default_nettype none

module fetch_queue import bpu_pkg::*; (
    input  logic clk,
    input  logic arst_n,
    fq_if.queue  fq
);

    pred_stream_t           mem [FQ_DEPTH];
    logic [FQ_PTR_SIZE-1:0] wr_ptr_q;
    logic [FQ_PTR_SIZE-1:0] rd_ptr_q;
    logic [FQ_CNT_SIZE-1:0] count_q;
    logic                   do_push;
    logic                   do_pop;

    assign fq.push_ready = (count_q != FQ_CNT_SIZE'(FQ_DEPTH));
    assign do_push       = fq.push && fq.push_ready && !fq.flush;
    assign do_pop        = fq.pop && (count_q != '0) && !fq.flush;

    assign fq.head  = mem[rd_ptr_q];
    assign fq.count = count_q;

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr_q] <= fq.push_data;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else if (fq.flush) begin
            wr_ptr_q <= '0;                       // Drop everything in flight
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;      // Idle or push with pop
            endcase
        end
    end

    // Count past depth means a push got in while full
    no_overfill_a: assert property (@(posedge clk) disable iff (!arst_n)
        count_q <= FQ_CNT_SIZE'(FQ_DEPTH));
    // Reader must check count before popping
    no_empty_pop_a: assert property (@(posedge clk) disable iff (!arst_n)
        fq.pop |-> count_q != '0);

endmodule

`default_nettype wire

//--- verilog/apb_bpu_port.sv
`timescale 1ns/100ps
`default_nettype none

module apb_bpu_port import bpu_pkg::*; (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     psel,
    input  logic                     penable,
    input  logic                     pwrite,
    input  logic [APB_ADDR_SIZE-1:0] paddr,
    input  logic [VADDR_SIZE-1:0]    pwdata,
    output logic [VADDR_SIZE-1:0]    prdata,
    output logic                     pready,
    fq_if.reader                     fq,
    output logic                     upd_valid,
    output btb_update_t              upd,
    output logic                     redirect_valid,
    output logic [VADDR_SIZE-1:0]    redirect_pc
);

    logic                  access;
    logic                  mapped;
    logic                  wr_en;
    logic                  rd_en;
    apb_reg_e              reg_sel;
    logic [VADDR_SIZE-1:0] upd_addr_q;
    logic [VADDR_SIZE-1:0] upd_target_q;
    logic                  redirect_q;

    assign access  = psel && penable;
    assign mapped  = (paddr[APB_ADDR_SIZE-1:5] == '0);
    assign reg_sel = apb_reg_e'(paddr[4:2]);
    assign wr_en   = access && pwrite && mapped;
    assign rd_en   = access && !pwrite && mapped;
    assign pready  = 1'b1;                        // No wait states

    // ------------------------------
    // Read side
    // ------------------------------
    always_comb begin
        prdata = '0;
        if (mapped && !pwrite) begin
            case (reg_sel)
                REG_STATUS:      prdata = VADDR_SIZE'(fq.count);
                REG_HEAD_START:  prdata = fq.head.start_addr;
                REG_HEAD_TARGET: prdata = fq.head.target;
                REG_HEAD_INFO:   prdata = VADDR_SIZE'({fq.head.hit, fq.head.taken, fq.head.size});
                default:         prdata = '0;               // Write-only words
            endcase
        end
    end

    assign fq.pop = rd_en && (reg_sel == REG_HEAD_INFO) && (fq.count != '0);

    // ------------------------------
    // Write side
    // ------------------------------
    always_ff @(posedge clk) begin
        if (wr_en && reg_sel == REG_UPD_ADDR) begin
            upd_addr_q <= pwdata;
        end
        if (wr_en && reg_sel == REG_UPD_TARGET) begin
            upd_target_q <= pwdata;
        end
        if (wr_en && reg_sel == REG_UPD_CTRL) begin
            upd <= '{start_addr: upd_addr_q, target: upd_target_q, offset: pwdata[2:0],
                     br_type: br_type_e'(pwdata[3]), real_taken: pwdata[4]};
        end
        if (wr_en && reg_sel == REG_REDIRECT) begin
            redirect_pc <= pwdata;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            upd_valid  <= 1'b0;
            redirect_q <= 1'b0;
        end else begin
            upd_valid  <= wr_en && (reg_sel == REG_UPD_CTRL);   // One-cycle strobes
            redirect_q <= wr_en && (reg_sel == REG_REDIRECT);
        end
    end

    assign redirect_valid = redirect_q;
    assign fq.flush       = redirect_q;

    penable_needs_psel_a: assert property (@(posedge clk) disable iff (!arst_n)
        penable |-> psel);

endmodule

`default_nettype wire

//--- verilog/bpu_top.sv
`timescale 1ns/100ps
`default_nettype none

module bpu_top import bpu_pkg::*; (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     psel,
    input  logic                     penable,
    input  logic                     pwrite,
    input  logic [APB_ADDR_SIZE-1:0] paddr,
    input  logic [VADDR_SIZE-1:0]    pwdata,
    output logic [VADDR_SIZE-1:0]    prdata,
    output logic                     pready
);

    logic [VADDR_SIZE-1:0] pc;
    pred_stream_t          pred;
    logic                  upd_valid;
    btb_update_t           upd;
    logic                  redirect_valid;
    logic [VADDR_SIZE-1:0] redirect_pc;

    fq_if fq_i ();

    pc_gen pc_gen_i (
        .clk            (clk),
        .arst_n         (arst_n),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .pc             (pc),
        .pred           (pred),
        .fq             (fq_i.producer)
    );

    ubtb ubtb_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .pc        (pc),
        .pred      (pred),
        .upd_valid (upd_valid),
        .upd       (upd)
    );

    fetch_queue fetch_queue_i (
        .clk    (clk),
        .arst_n (arst_n),
        .fq     (fq_i.queue)
    );

    apb_bpu_port apb_bpu_port_i (
        .clk            (clk),
        .arst_n         (arst_n),
        .psel           (psel),
        .penable        (penable),
        .pwrite         (pwrite),
        .paddr          (paddr),
        .pwdata         (pwdata),
        .prdata         (prdata),
        .pready         (pready),
        .fq             (fq_i.reader),
        .upd_valid      (upd_valid),
        .upd            (upd),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

endmodule

`default_nettype wire

//--- testbench/tb_bpu.sv
`timescale 1ns/100ps
`default_nettype none

module tb_bpu import bpu_pkg::*; ();

    typedef enum {UPDATE, REDIRECT, EXPECT_STREAMS} step_kind_e;

    typedef struct {
        step_kind_e            kind;
        logic [VADDR_SIZE-1:0] addr;
        logic [VADDR_SIZE-1:0] target;
        logic [2:0]            offset;
        br_type_e              br_type;
        logic                  taken;
        int                    count;
    } step_t;

    logic                     clk;
    logic                     arst_n;
    logic                     psel;
    logic                     penable;
    logic                     pwrite;
    logic [APB_ADDR_SIZE-1:0] paddr;
    logic [VADDR_SIZE-1:0]    pwdata;
    logic [VADDR_SIZE-1:0]    prdata;
    logic                     pready;

    step_t                 steps [$];
    logic [VADDR_SIZE-1:0] fetch_pc;             // Model of the next stream start
    logic                  way_en   [UBTB_SIZE];
    logic [11:0]           way_tag  [UBTB_SIZE];
    br_type_e              way_type [UBTB_SIZE];
    logic [2:0]            way_off  [UBTB_SIZE];
    logic [VADDR_SIZE-1:0] way_tgt  [UBTB_SIZE];
    logic [1:0]            way_ctr  [UBTB_SIZE];

    bpu_top dut_i (
        .clk     (clk),
        .arst_n  (arst_n),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1, "stopping at first error");
    endtask

    function automatic logic [APB_ADDR_SIZE-1:0] reg_addr(input apb_reg_e r);
        return {3'b000, r, 2'b00};
    endfunction

    // ------------------------------
    // APB bus
    // ------------------------------
    task automatic apb_write(input apb_reg_e r, input logic [VADDR_SIZE-1:0] data);
        psel    = 1'b1;                          // Setup phase
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = reg_addr(r);
        pwdata  = data;
        @(posedge clk);
        #5 penable = 1'b1;
        @(posedge clk);                          // Access completes here
        #5 psel = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_read(input apb_reg_e r, output logic [VADDR_SIZE-1:0] data);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = reg_addr(r);
        @(posedge clk);
        #5 penable = 1'b1;
        @(negedge clk);
        data = prdata;                           // Mid access phase
        if (!pready) begin
            abort_run("APB slave did not signal ready during a read access");
        end
        @(posedge clk);
        #5 psel = 1'b0;
        penable = 1'b0;
    endtask

    // ------------------------------
    // uBTB reference model
    // ------------------------------
    function automatic int find_way(input logic [VADDR_SIZE-1:0] addr);
        int way;
        way = -1;
        for (int i = 0; i < UBTB_SIZE; i++) begin
            if (way_en[i] && way_tag[i] == addr[13:2]) begin
                way = i;
            end
        end
        return way;
    endfunction

    function automatic pred_stream_t predict(input logic [VADDR_SIZE-1:0] addr);
        pred_stream_t p;
        int           way;
        way          = find_way(addr);
        p.start_addr = addr;
        p.hit        = (way >= 0);
        p.taken      = 1'b0;
        if (way >= 0) begin
            p.taken = (way_type[way] == BR_JUMP) || (way_ctr[way] >= 2'd2);
        end
        p.target = addr + 32'd32;                // Next sequential block
        p.size   = 4'd8;
        if (p.taken) begin
            p.target = way_tgt[way];
            p.size   = {1'b0, way_off[way]} + 4'd1;
        end
        return p;
    endfunction

    task automatic train_model(input step_t s);
        int way;
        way = find_way(s.addr);
        if (way >= 0) begin
            if (s.taken && way_ctr[way] != 2'd3) begin
                way_ctr[way] = way_ctr[way] + 2'd1;
            end else if (!s.taken && way_ctr[way] != 2'd0) begin
                way_ctr[way] = way_ctr[way] - 2'd1;
            end
        end else begin
            for (int i = UBTB_SIZE - 1; i >= 0; i--) begin
                if (!way_en[i]) begin
                    way = i;
                end
            end
            if (way < 0) begin
                abort_run("Stimulus table allocates more tags than the uBTB model can hold");
            end
            way_ctr[way] = s.taken ? 2'd2 : 2'd1;
        end
        way_en[way]   = 1'b1;
        way_tag[way]  = s.addr[13:2];
        way_type[way] = s.br_type;
        way_off[way]  = s.offset;
        way_tgt[way]  = s.target;
    endtask

    // ------------------------------
    // Checks
    // ------------------------------
    task automatic check_stream(input pred_stream_t got, input pred_stream_t exp);
        if (got !== exp) begin
            abort_run($sformatf({"Fail at %0t: stream start %h target %h size %0d taken %b",
                " hit %b, expected start %h target %h size %0d taken %b hit %b"},
                $time, got.start_addr, got.target, got.size, got.taken, got.hit,
                exp.start_addr, exp.target, exp.size, exp.taken, exp.hit));
        end
    endtask

    task automatic check_count(input logic [FQ_CNT_SIZE-1:0] got,
                               input logic [FQ_CNT_SIZE-1:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("Fail at %0t: queue count %0d, expected %0d", $time, got, exp));
        end
    endtask

    // Polled waits on STATUS
    task automatic wait_nonempty();
        logic [VADDR_SIZE-1:0] st;
        int                    tries;
        st    = '0;
        tries = 0;
        while (st[FQ_CNT_SIZE-1:0] == '0) begin
            if (tries == 40) begin
                abort_run($sformatf("Timeout at %0t: fetch queue stayed empty", $time));
            end else begin
                apb_read(REG_STATUS, st);
                tries++;
            end
        end
    endtask

    task automatic wait_full();
        logic [VADDR_SIZE-1:0] st;
        int                    tries;
        st    = '0;
        tries = 0;
        while (st[FQ_CNT_SIZE-1:0] != FQ_CNT_SIZE'(FQ_DEPTH)) begin
            if (tries == 40) begin
                abort_run($sformatf("Timeout at %0t: fetch queue never filled", $time));
            end else begin
                apb_read(REG_STATUS, st);
                tries++;
            end
        end
        apb_read(REG_STATUS, st);               // Must hold at depth
        check_count(st[FQ_CNT_SIZE-1:0], FQ_CNT_SIZE'(FQ_DEPTH));
    endtask

    // ------------------------------
    // Step handlers
    // ------------------------------
    task automatic apply_update(input step_t s);
        apb_write(REG_UPD_ADDR, s.addr);
        apb_write(REG_UPD_TARGET, s.target);
        apb_write(REG_UPD_CTRL, {27'd0, s.taken, s.br_type, s.offset});
        train_model(s);
    endtask

    task automatic apply_redirect(input logic [VADDR_SIZE-1:0] addr);
        apb_write(REG_REDIRECT, addr);
        fetch_pc = addr;
        wait_full();                             // Nothing pops, so it fills
    endtask

    task automatic expect_streams(input int n);
        pred_stream_t          got;
        pred_stream_t          exp;
        logic [VADDR_SIZE-1:0] w;
        for (int k = 0; k < n; k++) begin
            wait_nonempty();
            apb_read(REG_HEAD_START, w);
            got.start_addr = w;
            apb_read(REG_HEAD_TARGET, w);
            got.target = w;
            apb_read(REG_HEAD_INFO, w);          // Pops the head
            got.size  = w[3:0];
            got.taken = w[4];
            got.hit   = w[5];
            exp = predict(fetch_pc);
            check_stream(got, exp);
            fetch_pc = exp.target;
        end
    endtask

    task automatic add_step(input step_kind_e kind, input logic [VADDR_SIZE-1:0] addr,
                            input logic [VADDR_SIZE-1:0] target, input logic [2:0] offset,
                            input br_type_e br_type, input logic taken, input int count);
        step_t s;
        s = '{kind, addr, target, offset, br_type, taken, count};
        steps.push_back(s);
    endtask

    task automatic build_table();
        add_step(REDIRECT,       32'h1000, 32'h0,    3'd0, BR_COND, 1'b0, 0);
        add_step(EXPECT_STREAMS, 32'h0,    32'h0,    3'd0, BR_COND, 1'b0, 6);  // Empty BTB
        add_step(UPDATE,         32'h1040, 32'h2000, 3'd5, BR_JUMP, 1'b1, 0);
        add_step(REDIRECT,       32'h1000, 32'h0,    3'd0, BR_COND, 1'b0, 0);
        add_step(EXPECT_STREAMS, 32'h0,    32'h0,    3'd0, BR_COND, 1'b0, 5);
        add_step(UPDATE,         32'h2400, 32'h0300, 3'd2, BR_COND, 1'b1, 0);
        add_step(REDIRECT,       32'h2400, 32'h0,    3'd0, BR_COND, 1'b0, 0);
        add_step(EXPECT_STREAMS, 32'h0,    32'h0,    3'd0, BR_COND, 1'b0, 2);
        add_step(UPDATE,         32'h2400, 32'h0300, 3'd2, BR_COND, 1'b0, 0);
        add_step(UPDATE,         32'h2400, 32'h0300, 3'd2, BR_COND, 1'b0, 0);
        add_step(REDIRECT,       32'h2400, 32'h0,    3'd0, BR_COND, 1'b0, 0);
        add_step(EXPECT_STREAMS, 32'h0,    32'h0,    3'd0, BR_COND, 1'b0, 2);  // Counter at 0
        add_step(UPDATE,         32'h3000, 32'h3100, 3'd0, BR_JUMP, 1'b1, 0);
        add_step(UPDATE,         32'h3100, 32'h3200, 3'd7, BR_JUMP, 1'b1, 0);
        add_step(UPDATE,         32'h3200, 32'h3300, 3'd3, BR_JUMP, 1'b1, 0);
        add_step(UPDATE,         32'h3300, 32'h3400, 3'd6, BR_JUMP, 1'b1, 0);
        add_step(UPDATE,         32'h3400, 32'h3500, 3'd1, BR_JUMP, 1'b1, 0);
        add_step(UPDATE,         32'h3500, 32'h1040, 3'd4, BR_JUMP, 1'b1, 0);  // All ways full
        add_step(REDIRECT,       32'h3000, 32'h0,    3'd0, BR_COND, 1'b0, 0);
        add_step(EXPECT_STREAMS, 32'h0,    32'h0,    3'd0, BR_COND, 1'b0, 8);
        add_step(UPDATE,         32'h3200, 32'h3600, 3'd1, BR_JUMP, 1'b1, 0);
        add_step(REDIRECT,       32'h3000, 32'h0,    3'd0, BR_COND, 1'b0, 0);
        add_step(EXPECT_STREAMS, 32'h0,    32'h0,    3'd0, BR_COND, 1'b0, 4);
        add_step(REDIRECT,       32'h3300, 32'h0,    3'd0, BR_COND, 1'b0, 0);  // Mid chain
        add_step(EXPECT_STREAMS, 32'h0,    32'h0,    3'd0, BR_COND, 1'b0, 4);
        add_step(REDIRECT,       32'h2400, 32'h0,    3'd0, BR_COND, 1'b0, 0);
        add_step(EXPECT_STREAMS, 32'h0,    32'h0,    3'd0, BR_COND, 1'b0, 1);
    endtask

    // ------------------------------
    // Main sequence
    // ------------------------------
    initial begin
        step_t s;
        arst_n   = 1'b0;
        psel     = 1'b0;
        penable  = 1'b0;
        pwrite   = 1'b0;
        paddr    = '0;
        pwdata   = '0;
        fetch_pc = '0;
        void'($urandom(86854));
        for (int i = 0; i < UBTB_SIZE; i++) begin
            way_en[i] = 1'b0;
        end
        build_table();
        repeat (10) @(posedge clk);
        #5 arst_n = 1'b1;
        foreach (steps[i]) begin
            s = steps[i];
            case (s.kind)
                UPDATE:   apply_update(s);
                REDIRECT: apply_redirect(s.addr);
                default:  expect_streams(s.count);
            endcase
            repeat ($urandom_range(3, 0)) begin  // Idle gap between steps
                @(posedge clk);
                #5;
            end
        end
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- project.f
verilog/bpu_pkg.sv
verilog/fq_if.sv
verilog/pc_gen.sv
verilog/ubtb.sv
verilog/fetch_queue.sv
verilog/apb_bpu_port.sv
verilog/bpu_top.sv
testbench/tb_bpu.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_bpu
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
SOURCES   := $(wildcard verilog/*.sv) $(wildcard testbench/*.sv)

.PHONY: all run lint clean

all: run

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
